// ==== design/power_seq_config.svh ====
// Power sequencer configuration
// Rail count, counter widths and the position of each rail in the sequence
`ifndef POWER_SEQ_CONFIG_SVH
`define POWER_SEQ_CONFIG_SVH

`define RAIL_COUNT 15

// Settle delay ends when the top bit of the settle counter sets
`define SETTLE_BITS 17
`define WATCHDOG_BITS 24

// Rail positions, power-up order
`define RAIL_ATX 0
`define RAIL_MISCIO 1
`define RAIL_VDNA 2
`define RAIL_VDNB 3
`define RAIL_AVDD 4
`define RAIL_VIOA 5
`define RAIL_VIOB 6
`define RAIL_VDDA 7
`define RAIL_VDDB 8
`define RAIL_VCSA 9
`define RAIL_VCSB 10
`define RAIL_VPPAB 11
`define RAIL_VPPCD 12
`define RAIL_VDDRAB 13
`define RAIL_VDDRCD 14

// Second CPU rails: vdnb, viob, vddb, vcsb, vppcd, vddrcd
`define CPUB_RAIL_MASK 15'b101_0101_0100_1000

`endif

// ==== design/power_seq_pkg.sv ====
// Power sequencer types
// Rail vectors, named pin groups, status word and sequencer activity
`include "power_seq_config.svh"

package power_seq_pkg;

	// One bit per rail, bit 0 is ATX
	typedef logic [`RAIL_COUNT-1:0] rail_vec_t;

	// Power good pins, declared top rail first so bit order matches rail_vec_t
	typedef struct packed {
		logic vddrcd_pg;
		logic vddrab_pg;
		logic vppcd_pg;
		logic vppab_pg;
		logic vcsb_pg;
		logic vcsa_pg;
		logic vddb_pg;
		logic vdda_pg;
		logic viob_pg;
		logic vioa_pg;
		logic avdd_pg;
		logic vdnb_pg;
		logic vdna_pg;
		logic miscio_pg;
		logic atx_pg;
	} rail_pg_pins_t;

	// Enable pins, atx_en is active low
	typedef struct packed {
		logic vttcd_en;
		logic vddrcd_en;
		logic vttab_en;
		logic vddrab_en;
		logic vppcd_en;
		logic vppab_en;
		logic vcsb_en;
		logic vcsa_en;
		logic vddb_en;
		logic vdda_en;
		logic viob_en;
		logic vioa_en;
		logic avdd_en;
		logic vdnb_en;
		logic vdna_en;
		logic miscio_en;
		logic atx_en;
	} rail_en_pins_t;

	typedef struct packed {
		logic sysgood;
		logic sysen_seen;
		logic err_found;
		logic operation_err;
		logic wait_err;
		logic cpub_present;
	} seq_status_t;

	// What the sequencer does in a given cycle
	typedef enum logic [1:0] {
		seq_idle,
		seq_settling,
		seq_waiting,
		seq_fault
	} settle_state_t;

endpackage

// ==== design/pg_input_stage.sv ====
// Power sequencer input stage
// Gathers the power good pins into rail order, masks absent second-CPU
// rails and synchronizes power good and the system request to clk_in
`include "power_seq_config.svh"

module pg_input_stage import power_seq_pkg::*; (
	input  logic          clk_in,
	input  logic          rst,
	input  rail_pg_pins_t pg_pins,
	input  logic          sysen,
	input  logic          debug_n,
	input  logic          cpub_present_n,
	input  rail_vec_t     rail_en,
	output rail_vec_t     pg_sync,
	output logic          sysen_sync,
	output logic          cpub_present
);

	rail_vec_t pg_raw;
	rail_vec_t pg_masked;
	rail_vec_t pg_meta;
	logic      sysen_req;
	logic      sysen_meta;

	always_comb begin
		pg_raw[`RAIL_ATX]    = pg_pins.atx_pg;
		pg_raw[`RAIL_MISCIO] = pg_pins.miscio_pg;
		pg_raw[`RAIL_VDNA]   = pg_pins.vdna_pg;
		pg_raw[`RAIL_VDNB]   = pg_pins.vdnb_pg;
		pg_raw[`RAIL_AVDD]   = pg_pins.avdd_pg;
		pg_raw[`RAIL_VIOA]   = pg_pins.vioa_pg;
		pg_raw[`RAIL_VIOB]   = pg_pins.viob_pg;
		pg_raw[`RAIL_VDDA]   = pg_pins.vdda_pg;
		pg_raw[`RAIL_VDDB]   = pg_pins.vddb_pg;
		pg_raw[`RAIL_VCSA]   = pg_pins.vcsa_pg;
		pg_raw[`RAIL_VCSB]   = pg_pins.vcsb_pg;
		pg_raw[`RAIL_VPPAB]  = pg_pins.vppab_pg;
		pg_raw[`RAIL_VPPCD]  = pg_pins.vppcd_pg;
		pg_raw[`RAIL_VDDRAB] = pg_pins.vddrab_pg;
		pg_raw[`RAIL_VDDRCD] = pg_pins.vddrcd_pg;
	end

	// With CPU B absent its rails look good as soon as they are enabled
	assign pg_masked = pg_raw | (`CPUB_RAIL_MASK & rail_en & {`RAIL_COUNT{cpub_present_n}});

	// Debug strap low requests power without the BMC
	assign sysen_req = sysen | ~debug_n;

	always_ff @(posedge clk_in) begin
		if (rst) begin
			pg_meta      <= '0;
			pg_sync      <= '0;
			sysen_meta   <= 1'b0;
			sysen_sync   <= 1'b0;
			cpub_present <= 1'b0;
		end else begin
			pg_meta      <= pg_masked;
			pg_sync      <= pg_meta;
			sysen_meta   <= sysen_req;
			sysen_sync   <= sysen_meta;
			cpub_present <= ~cpub_present_n;
		end
	end

endmodule

// ==== design/rail_sequencer.sv ====
// Rail sequencer
// Times the settle delay of each rail after its power good arrives,
// watches for power good that never comes and for rails that drop
// after settling, and latches both kinds of error until cleared
`include "power_seq_config.svh"

module rail_sequencer import power_seq_pkg::*; #(
	parameter int SETTLE_BITS   = `SETTLE_BITS,
	parameter int WATCHDOG_BITS = `WATCHDOG_BITS
) (
	input  logic      clk_in,
	input  logic      rst,
	input  rail_vec_t pg_sync,
	input  logic      sysen_sync,
	input  rail_vec_t rail_en,
	input  logic      clear_err,
	output rail_vec_t settled,
	output logic      err_found,
	output logic      wait_err,
	output logic      operation_err
);

	logic [SETTLE_BITS-1:0]   settle_cnt;
	logic [WATCHDOG_BITS-1:0] watchdog_cnt;

	rail_vec_t     settle_ready;
	rail_vec_t     settle_pick;
	rail_vec_t     pg_missing;
	rail_vec_t     pg_lost;
	settle_state_t seq_state;

	// Enabled and powered but still inside the settle delay
	assign settle_ready = rail_en & pg_sync & ~settled;

	// Lowest such rail only, one settle counter is shared
	assign settle_pick = settle_ready & (~settle_ready + 1'b1);

	// Enabled but no power good yet
	assign pg_missing = rail_en & ~pg_sync;

	// Rail went away after it had settled
	assign pg_lost = settled & ~pg_sync;

	always_comb begin
		if (!sysen_sync || err_found) begin
			seq_state = seq_fault;
		end else if (|settle_ready) begin
			seq_state = seq_settling;
		end else if (|pg_missing) begin
			seq_state = seq_waiting;
		end else begin
			seq_state = seq_idle;
		end
	end

	always_ff @(posedge clk_in) begin
		if (rst) begin
			settle_cnt    <= '0;
			watchdog_cnt  <= '0;
			settled       <= '0;
			wait_err      <= 1'b0;
			operation_err <= 1'b0;
			err_found     <= 1'b0;
		end else if (clear_err) begin
			// Settled flags stay, the enable chain rebuilds from them
			settle_cnt    <= '0;
			watchdog_cnt  <= '0;
			wait_err      <= 1'b0;
			operation_err <= 1'b0;
			err_found     <= 1'b0;
		end else begin
			case (seq_state)
				seq_fault: begin
					settle_cnt   <= '0;
					watchdog_cnt <= '0;
					settled      <= '0;
				end
				seq_settling: begin
					watchdog_cnt <= '0;
					if (settle_cnt[SETTLE_BITS-1]) begin
						settle_cnt <= '0;
						settled    <= settled | settle_pick;
					end else begin
						settle_cnt <= settle_cnt + 1'b1;
					end
				end
				seq_waiting: begin
					if (watchdog_cnt[WATCHDOG_BITS-1]) begin
						watchdog_cnt <= '0;
						wait_err     <= 1'b1;
					end else begin
						watchdog_cnt <= watchdog_cnt + 1'b1;
					end
				end
				default: begin
					// Nothing pending, counters hold
				end
			endcase

			if (|pg_lost) begin
				operation_err <= 1'b1;
			end
			if (wait_err || operation_err) begin
				err_found <= 1'b1;
			end
		end
	end

endmodule

// ==== design/rail_enable_stage.sv ====
// Rail enable stage
// Builds the enable chain: up in order behind settled rails, down in
// reverse order behind falling power good, all off on a latched error.
// Drives the named enable pins and system good
`include "power_seq_config.svh"

module rail_enable_stage import power_seq_pkg::*; (
	input  logic          clk_in,
	input  logic          rst,
	input  logic          sysen_sync,
	input  rail_vec_t     pg_sync,
	input  rail_vec_t     settled,
	input  logic          err_found,
	input  logic          cpub_present,
	output rail_vec_t     rail_en,
	output rail_en_pins_t en_pins,
	output logic          sysgood
);

	rail_vec_t chain_up;
	rail_vec_t chain_down;
	rail_vec_t rail_en_next;
	rail_vec_t rail_en_masked;

	function automatic rail_en_pins_t map_pins(input rail_vec_t en);
		rail_en_pins_t pins;
		pins.atx_en    = ~en[`RAIL_ATX];
		pins.miscio_en = en[`RAIL_MISCIO];
		pins.vdna_en   = en[`RAIL_VDNA];
		pins.vdnb_en   = en[`RAIL_VDNB];
		pins.avdd_en   = en[`RAIL_AVDD];
		pins.vioa_en   = en[`RAIL_VIOA];
		pins.viob_en   = en[`RAIL_VIOB];
		pins.vdda_en   = en[`RAIL_VDDA];
		pins.vddb_en   = en[`RAIL_VDDB];
		pins.vcsa_en   = en[`RAIL_VCSA];
		pins.vcsb_en   = en[`RAIL_VCSB];
		pins.vppab_en  = en[`RAIL_VPPAB];
		pins.vppcd_en  = en[`RAIL_VPPCD];
		pins.vddrab_en = en[`RAIL_VDDRAB];
		// Termination follows its DDR supply
		pins.vttab_en  = en[`RAIL_VDDRAB];
		pins.vddrcd_en = en[`RAIL_VDDRCD];
		pins.vttcd_en  = en[`RAIL_VDDRCD];
		return pins;
	endfunction

	// Rail i may come up once rail i-1 has settled, rail 0 needs only the request
	assign chain_up = {settled[`RAIL_COUNT-2:0], 1'b1};

	// Rail i stays up while rail i+1 still has power good, top rail has no follower
	assign chain_down = {1'b0, pg_sync[`RAIL_COUNT-1:1]};

	assign rail_en_next = ((chain_up & {`RAIL_COUNT{sysen_sync}}) | chain_down)
		& {`RAIL_COUNT{~err_found}};

	// CPU B pins stay low when the socket is empty
	assign rail_en_masked = rail_en & ~(`CPUB_RAIL_MASK & {`RAIL_COUNT{~cpub_present}});

	always_ff @(posedge clk_in) begin
		if (rst) begin
			rail_en <= '0;
			en_pins <= map_pins('0);
			sysgood <= 1'b0;
		end else begin
			rail_en <= rail_en_next;
			en_pins <= map_pins(rail_en_masked);
			sysgood <= settled[`RAIL_VDDRCD];
		end
	end

endmodule

// ==== design/power_seq_top.sv ====
// Power sequencer top level
// Input synchronization, settle and watchdog timing, and the enable
// chain, with a status word for the board controller
`include "power_seq_config.svh"

module power_seq_top import power_seq_pkg::*; #(
	parameter int SETTLE_BITS   = `SETTLE_BITS,
	parameter int WATCHDOG_BITS = `WATCHDOG_BITS
) (
	input  logic          clk_in,
	input  logic          rst,
	input  rail_pg_pins_t pg_pins,
	input  logic          sysen,
	input  logic          debug_n,
	input  logic          cpub_present_n,
	input  logic          clear_err,
	output rail_en_pins_t en_pins,
	output logic          sysgood,
	output seq_status_t   status
);

	rail_vec_t pg_sync;
	rail_vec_t settled;
	rail_vec_t rail_en;
	logic      sysen_sync;
	logic      cpub_present;
	logic      err_found;
	logic      wait_err;
	logic      operation_err;

	pg_input_stage input_i (
		.clk_in         (clk_in),
		.rst            (rst),
		.pg_pins        (pg_pins),
		.sysen          (sysen),
		.debug_n        (debug_n),
		.cpub_present_n (cpub_present_n),
		.rail_en        (rail_en),
		.pg_sync        (pg_sync),
		.sysen_sync     (sysen_sync),
		.cpub_present   (cpub_present)
	);

	rail_sequencer #(
		.SETTLE_BITS   (SETTLE_BITS),
		.WATCHDOG_BITS (WATCHDOG_BITS)
	) sequencer_i (
		.clk_in        (clk_in),
		.rst           (rst),
		.pg_sync       (pg_sync),
		.sysen_sync    (sysen_sync),
		.rail_en       (rail_en),
		.clear_err     (clear_err),
		.settled       (settled),
		.err_found     (err_found),
		.wait_err      (wait_err),
		.operation_err (operation_err)
	);

	// Enables loop back to the input stage and the sequencer
	rail_enable_stage enable_i (
		.clk_in       (clk_in),
		.rst          (rst),
		.sysen_sync   (sysen_sync),
		.pg_sync      (pg_sync),
		.settled      (settled),
		.err_found    (err_found),
		.cpub_present (cpub_present),
		.rail_en      (rail_en),
		.en_pins      (en_pins),
		.sysgood      (sysgood)
	);

	always_comb begin
		status.sysgood       = sysgood;
		status.sysen_seen    = sysen_sync;
		status.err_found     = err_found;
		status.operation_err = operation_err;
		status.wait_err      = wait_err;
		status.cpub_present  = cpub_present;
	end

endmodule

// ==== tb/rail_model.sv ====
// Supply model for the power sequencer testbench
// Raises each rail's power good 3 to 10 cycles after its enable pin.
// Rails in stuck_mask never come good, rails in drop_mask lose power good
`include "power_seq_config.svh"

module rail_model import power_seq_pkg::*; (
	input  logic          clk_in,
	input  rail_en_pins_t en_pins,
	input  rail_vec_t     stuck_mask,
	input  rail_vec_t     drop_mask,
	output rail_pg_pins_t pg_pins,
	output rail_vec_t     rail_on
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] rng;
	logic [3:0]  delay_left [`RAIL_COUNT];
	rail_vec_t   armed;
	rail_vec_t   pg;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// vtt pins are skipped, ATX pin is active low
	assign rail_on = {en_pins.vddrcd_en, en_pins.vddrab_en, en_pins[12:1], ~en_pins.atx_en};
	assign pg_pins = pg;

	initial begin
		rng   = 32'h68ea_ad86;
		armed = '0;
		pg    = '0;
		for (int i = 0; i < `RAIL_COUNT; i++) begin
			delay_left[i] = '0;
		end
	end

	always @(posedge clk_in) begin
		#1;
		for (int i = 0; i < `RAIL_COUNT; i++) begin
			if (!rail_on[i] || drop_mask[i]) begin
				pg[i]    = 1'b0;
				armed[i] = 1'b0;
			end else if (!pg[i] && !stuck_mask[i]) begin
				if (!armed[i]) begin
					rng           = xorshift32(rng);
					delay_left[i] = 4'd2 + rng[2:0];
					armed[i]      = 1'b1;
				end else if (delay_left[i] == 0) begin
					pg[i] = 1'b1;
				end else begin
					delay_left[i] = delay_left[i] - 1'b1;
				end
			end
		end
	end

endmodule

// ==== tb/power_seq_tb.sv ====
// Power sequencer testbench
// Power-up, pin mapping, power-down, watchdog, operation error and
// second CPU absent, run against the behavioral supply model
`include "power_seq_config.svh"

module power_seq_tb import power_seq_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int SETTLE_BITS   = 4;
	localparam int WATCHDOG_BITS = 7;
	localparam int STUCK_RAIL    = `RAIL_VIOA;
	localparam int DROP_RAIL     = `RAIL_VDDA;

	// Worst case per rail from model delay, sync, settle count and register stages
	localparam int RAIL_BOUND  = 10 + 2 + 2**(SETTLE_BITS-1) + 1 + 6;
	localparam int UP_BOUND    = `RAIL_COUNT * RAIL_BOUND + 6;
	localparam int DOWN_BOUND  = `RAIL_COUNT * 8;
	localparam int WD_BOUND    = 2**(WATCHDOG_BITS-1) + 1 + 8;
	localparam int CYCLE_LIMIT = 6 * (UP_BOUND + 10 + DOWN_BOUND
		+ 2 * UP_BOUND + WD_BOUND + DOWN_BOUND + UP_BOUND + 30 + UP_BOUND + DOWN_BOUND);

	// Conditions that wait_for can wait on
	localparam int SYSGOOD_HIGH = 0;
	localparam int SYSGOOD_LOW  = 1;
	localparam int ALL_OFF      = 2;
	localparam int ERROR_SET    = 3;
	localparam int STUCK_ON     = 4;

	logic          clk_in;
	logic          rst;
	logic          sysen;
	logic          debug_n;
	logic          cpub_present_n;
	logic          clear_err;
	rail_pg_pins_t pg_pins;
	rail_en_pins_t en_pins;
	logic          sysgood;
	seq_status_t   status;
	rail_vec_t     stuck_mask;
	rail_vec_t     drop_mask;
	rail_vec_t     rail_on;
	rail_vec_t     prev_on;
	logic          check_order;
	int            test_errors;
	int            total_errors;
	int            tests_run;
	int            tests_ok;
	int            cycles;

	power_seq_top #(
		.SETTLE_BITS   (SETTLE_BITS),
		.WATCHDOG_BITS (WATCHDOG_BITS)
	) dut_i (
		.clk_in         (clk_in),
		.rst            (rst),
		.pg_pins        (pg_pins),
		.sysen          (sysen),
		.debug_n        (debug_n),
		.cpub_present_n (cpub_present_n),
		.clear_err      (clear_err),
		.en_pins        (en_pins),
		.sysgood        (sysgood),
		.status         (status)
	);

	rail_model supply_i (
		.clk_in     (clk_in),
		.en_pins    (en_pins),
		.stuck_mask (stuck_mask),
		.drop_mask  (drop_mask),
		.pg_pins    (pg_pins),
		.rail_on    (rail_on)
	);

	// ATX pin inverted and each vtt pin copies its vddr rail
	function automatic rail_en_pins_t expected_pins(input rail_vec_t on, input logic present);
		rail_vec_t en;
		en = present ? on : (on & ~`CPUB_RAIL_MASK);
		return {en[14], en[14], en[13], en[13], en[12:1], ~en[0]};
	endfunction

	function automatic logic probe(input int sel);
		case (sel)
			SYSGOOD_HIGH: return sysgood;
			SYSGOOD_LOW:  return !sysgood;
			ALL_OFF:      return rail_on == '0;
			ERROR_SET:    return status.err_found;
			STUCK_ON:     return rail_on[STUCK_RAIL];
			default:      return 1'b0;
		endcase
	endfunction

	task automatic show_mismatch(input string sig, input logic [31:0] got,
			input logic [31:0] exp);
		$display("Mismatch %s: got %h expected %h", sig, got, exp);
		test_errors++;
	endtask

	task automatic next_cycle(input int n);
		repeat (n) @(posedge clk_in);
		#1;
	endtask

	task automatic wait_for(input int sel, input int bound, input string what);
		int n;
		n = 0;
		while (!probe(sel) && n < bound) begin
			@(negedge clk_in);
			n++;
		end
		assert (probe(sel)) else begin
			$display("Gave up waiting: %s did not happen within %0d cycles", what, bound);
			test_errors++;
		end
		next_cycle(1);
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			$display("%s: ok", name);
			tests_ok++;
		end else begin
			$display("%s: %0d errors", name, test_errors);
			total_errors += test_errors;
		end
		tests_run++;
		test_errors = 0;
	endtask

	initial begin
		clk_in = 1'b0;
		forever #2 clk_in = ~clk_in;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk_in);
			cycles++;
		end
		$display("Timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
		$display("test failed");
		$finish;
	end

	// Pin mapping every cycle, and sequence order while check_order is set
	always @(negedge clk_in) begin
		if (!rst) begin
			assert (en_pins == expected_pins(rail_on, !cpub_present_n)) else
				show_mismatch("en_pins", en_pins, expected_pins(rail_on, !cpub_present_n));
			for (int i = 0; i < `RAIL_COUNT; i++) begin
				if (check_order && i > 0 && rail_on[i] && !prev_on[i]) begin
					assert (pg_pins[i-1]) else begin
						$display("Rail %0d enabled before rail %0d had power good", i, i - 1);
						test_errors++;
					end
				end
				if (check_order && i < `RAIL_COUNT - 1 && !rail_on[i] && prev_on[i]) begin
					assert (!pg_pins[i+1]) else begin
						$display("Rail %0d disabled while rail %0d still had power good", i, i + 1);
						test_errors++;
					end
				end
			end
			prev_on = rail_on;
		end
	end

	initial begin
		rst            = 1'b1;
		sysen          = 1'b0;
		debug_n        = 1'b1;
		cpub_present_n = 1'b0;
		clear_err      = 1'b0;
		stuck_mask     = '0;
		drop_mask      = '0;
		prev_on        = '0;
		check_order    = 1'b1;
		test_errors    = 0;
		total_errors   = 0;
		tests_run      = 0;
		tests_ok       = 0;
		next_cycle(3);
		assert (status == '0) else show_mismatch("status", status, 0);
		assert (en_pins.atx_en == 1'b1) else show_mismatch("en_pins.atx_en", en_pins.atx_en, 1);
		rst = 1'b0;
		next_cycle(1);

		sysen = 1'b1;
		wait_for(SYSGOOD_HIGH, UP_BOUND, "sysgood rising");
		assert (rail_on == '1) else show_mismatch("rail_on", rail_on, 15'h7fff);
		// Powered up with CPU B present and no errors
		assert (status == 6'b11_0001) else show_mismatch("status", status, 6'b11_0001);
		finish_test("Power-up order");

		repeat (8) begin
			@(negedge clk_in);
			assert (en_pins.atx_en == 1'b0) else show_mismatch("en_pins.atx_en", en_pins.atx_en, 0);
			assert (en_pins.vttab_en == en_pins.vddrab_en) else
				show_mismatch("en_pins.vttab_en", en_pins.vttab_en, en_pins.vddrab_en);
			assert (en_pins.vttcd_en == en_pins.vddrcd_en) else
				show_mismatch("en_pins.vttcd_en", en_pins.vttcd_en, en_pins.vddrcd_en);
		end
		next_cycle(1);
		finish_test("Pin mapping");

		sysen = 1'b0;
		wait_for(SYSGOOD_LOW, 10, "sysgood falling");
		wait_for(ALL_OFF, DOWN_BOUND, "all rails off");
		finish_test("Power-down order");

		stuck_mask[STUCK_RAIL] = 1'b1;
		sysen = 1'b1;
		wait_for(STUCK_ON, UP_BOUND, "stuck rail enabled");
		wait_for(ALL_OFF, WD_BOUND, "all rails off after watchdog");
		assert (status.wait_err) else show_mismatch("status.wait_err", status.wait_err, 1);
		assert (status.err_found) else show_mismatch("status.err_found", status.err_found, 1);
		stuck_mask = '0;
		clear_err = 1'b1;
		next_cycle(1);
		clear_err = 1'b0;
		next_cycle(1);
		assert ({status.err_found, status.wait_err} == 2'b00) else
			show_mismatch("status err bits", {status.err_found, status.wait_err}, 0);
		wait_for(SYSGOOD_HIGH, UP_BOUND, "sysgood after clear");
		sysen = 1'b0;
		wait_for(ALL_OFF, DOWN_BOUND, "all rails off");
		finish_test("Watchdog error");

		sysen = 1'b1;
		wait_for(SYSGOOD_HIGH, UP_BOUND, "sysgood rising");
		drop_mask[DROP_RAIL] = 1'b1;
		wait_for(ERROR_SET, 10, "err_found after power good loss");
		assert (status.operation_err) else
			show_mismatch("status.operation_err", status.operation_err, 1);
		wait_for(ALL_OFF, 8, "all rails off after operation error");
		drop_mask = '0;
		sysen = 1'b0;
		next_cycle(4);
		clear_err = 1'b1;
		next_cycle(1);
		clear_err = 1'b0;
		next_cycle(1);
		assert ({status.err_found, status.operation_err} == 2'b00) else
			show_mismatch("status err bits", {status.err_found, status.operation_err}, 0);
		finish_test("Operation error");

		// Absent second-CPU rails never show power good at the pins
		check_order = 1'b0;
		cpub_present_n = 1'b1;
		next_cycle(3);
		sysen = 1'b1;
		wait_for(SYSGOOD_HIGH, UP_BOUND, "sysgood with second CPU absent");
		assert (rail_on == rail_vec_t'(~`CPUB_RAIL_MASK)) else
			show_mismatch("rail_on", rail_on, rail_vec_t'(~`CPUB_RAIL_MASK));
		assert (!status.cpub_present) else
			show_mismatch("status.cpub_present", status.cpub_present, 0);
		sysen = 1'b0;
		wait_for(ALL_OFF, DOWN_BOUND, "all rails off");
		finish_test("Second CPU absent");

		$display("Tests run %0d, ok %0d, errors %0d", tests_run, tests_ok, total_errors);
		if (total_errors == 0 && tests_ok == tests_run) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== power_seq_top.f ====
+incdir+design
design/power_seq_pkg.sv
design/pg_input_stage.sv
design/rail_sequencer.sv
design/rail_enable_stage.sv
design/power_seq_top.sv
tb/rail_model.sv
tb/power_seq_tb.sv

// ==== Bender.yml ====
package:
  name: power_seq

sources:
  - include_dirs:
      - design
    files:
      - design/power_seq_pkg.sv
      - design/pg_input_stage.sv
      - design/rail_sequencer.sv
      - design/rail_enable_stage.sv
      - design/power_seq_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/rail_model.sv
      - tb/power_seq_tb.sv
